// ==== hw/axi_upsize_pkg.sv ====
// AXI write-channel upsizer shared definitions
// channel widths, width ratio, FIFO entry sizes and the wide-word views
`default_nettype none

package axi_upsize_pkg;

    // ==============================
    // AXI field widths
    // ==============================
    localparam int addr_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;
    localparam int size_w = 3;
    localparam int resp_w = 2;

    // narrow slave side and wide master side
    localparam int s_dw = 32;
    localparam int m_dw = 128;
    localparam int s_kw = s_dw / 8;
    localparam int m_kw = m_dw / 8;

    localparam int ratio      = m_dw / s_dw;
    localparam int ratio_log2 = $clog2(ratio);

    // longest slave burst accepted
    localparam int max_beats = 16;

    // ==============================
    // FIFO entry widths
    // ==============================
    // aw entry is {addr, id, len, size}
    localparam int aw_fifo_w = addr_w + id_w + len_w + size_w;
    // w entry is {last, strb, data}
    localparam int w_fifo_w  = 1 + m_kw + m_dw;
    // b entry is {id, resp}
    localparam int b_fifo_w  = id_w + resp_w;

    // wide data word, whole or as narrow lanes
    typedef union packed {
        logic [m_dw-1:0]             word;
        logic [ratio-1:0][s_dw-1:0]  lane;
    } wide_word_t;

    // wide strobe word, same two views
    typedef union packed {
        logic [m_kw-1:0]             word;
        logic [ratio-1:0][s_kw-1:0]  lane;
    } wide_strb_t;

endpackage

`default_nettype wire

// ==== hw/sync_fifo.sv ====
// Single-clock FIFO with registered read data
// count-based not-empty and not-almost-full flags, rvld one cycle after a pop
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 8
) (
    input  logic             m_axi_aclk,
    input  logic             s_axi_arst,
    input  logic             wen,
    input  logic [width-1:0] wdata,
    input  logic             ren,
    output logic [width-1:0] rdata,
    output logic             rvld,
    output logic             nempty,
    output logic             nafull
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    // two free slots kept back for the registered write from the producer
    localparam int afull_lvl = depth - 2;

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wptr;
    logic [ptr_w-1:0] rptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push   = wen;
    assign pop    = ren & nempty;
    assign nempty = (count != '0);
    assign nafull = (count < cnt_w'(afull_lvl));

    // ==============================
    // pointers and occupancy
    // ==============================
    always_ff @(posedge m_axi_aclk or posedge s_axi_arst) begin
        if (s_axi_arst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
            rvld  <= 1'b0;
        end else begin
            rvld <= pop;
            if (push) begin
                wptr <= ptr_inc(wptr);
            end
            if (pop) begin
                rptr <= ptr_inc(rptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge m_axi_aclk) begin
        if (push) begin
            mem[wptr] <= wdata;
        end
        if (pop) begin
            rdata <= mem[rptr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/aw_translate.sv ====
// AW channel translation for the wide port
// scales burst length and size by the width ratio, registers the entry
// and its write strobe into the AW FIFO
`timescale 1ns/1ps
`default_nettype none

module aw_translate (
    input  logic                               m_axi_aclk,
    input  logic                               s_axi_arst,
    input  logic [axi_upsize_pkg::addr_w-1:0]  s_axi_awaddr,
    input  logic [axi_upsize_pkg::id_w-1:0]    s_axi_awid,
    input  logic [axi_upsize_pkg::len_w-1:0]   s_axi_awlen,
    input  logic [axi_upsize_pkg::size_w-1:0]  s_axi_awsize,
    input  logic                               s_axi_awvalid,
    output logic                               s_axi_awready,
    input  logic                               fifo_nafull,
    output logic                               fifo_wen,
    output logic [axi_upsize_pkg::aw_fifo_w-1:0] fifo_wdata
);

    localparam int len_w  = axi_upsize_pkg::len_w;
    localparam int size_w = axi_upsize_pkg::size_w;

    logic              aw_xfer;
    logic [len_w:0]    beats;
    logic [len_w:0]    wide_beats;
    logic [len_w-1:0]  wide_len;
    logic [size_w-1:0] wide_size;

    assign s_axi_awready = fifo_nafull;
    assign aw_xfer       = s_axi_awvalid & s_axi_awready;

    // ==============================
    // length and size rewrite
    // ==============================
    always_comb begin
        beats      = {1'b0, s_axi_awlen} + 1'b1;
        // round up to whole wide beats
        wide_beats = (beats + (len_w + 1)'(axi_upsize_pkg::ratio - 1))
                     >> axi_upsize_pkg::ratio_log2;
        wide_len   = len_w'(wide_beats - 1'b1);
        wide_size  = s_axi_awsize + size_w'(axi_upsize_pkg::ratio_log2);
    end

    // write enable follows the transfer by one cycle
    always_ff @(posedge m_axi_aclk or posedge s_axi_arst) begin
        if (s_axi_arst) begin
            fifo_wen <= 1'b0;
        end else begin
            fifo_wen <= aw_xfer;
        end
    end

    // entry layout {addr, id, len, size}
    always_ff @(posedge m_axi_aclk) begin
        if (aw_xfer) begin
            fifo_wdata <= {s_axi_awaddr, s_axi_awid, wide_len, wide_size};
        end
    end

endmodule

`default_nettype wire

// ==== hw/w_packer.sv ====
// W channel packer
// collects narrow write beats into wide words lane by lane, with the
// strobes in matching lanes, and flushes a partial word on wlast
`timescale 1ns/1ps
`default_nettype none

module w_packer (
    input  logic                              m_axi_aclk,
    input  logic                              s_axi_arst,
    input  logic [axi_upsize_pkg::s_dw-1:0]   s_axi_wdata,
    input  logic [axi_upsize_pkg::s_kw-1:0]   s_axi_wstrb,
    input  logic                              s_axi_wlast,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    input  logic                              fifo_nafull,
    output logic                              fifo_wen,
    output logic [axi_upsize_pkg::w_fifo_w-1:0] fifo_wdata
);

    localparam int lane_w = axi_upsize_pkg::ratio_log2;
    localparam int m_kw   = axi_upsize_pkg::m_kw;

    axi_upsize_pkg::wide_word_t data_q;
    axi_upsize_pkg::wide_strb_t strb_q;
    logic                       last_q;
    logic [lane_w-1:0]          lane_cnt;
    logic                       w_xfer;
    logic                       last_lane;
    logic                       word_done;

    assign s_axi_wready = fifo_nafull;
    assign w_xfer       = s_axi_wvalid & s_axi_wready;
    assign last_lane    = (lane_cnt == lane_w'(axi_upsize_pkg::ratio - 1));
    // word is complete when the top lane fills or the burst ends
    assign word_done    = w_xfer & (s_axi_wlast | last_lane);

    // ==============================
    // lane counter and push
    // ==============================
    always_ff @(posedge m_axi_aclk or posedge s_axi_arst) begin
        if (s_axi_arst) begin
            lane_cnt <= '0;
            fifo_wen <= 1'b0;
        end else begin
            fifo_wen <= word_done;
            if (word_done) begin
                lane_cnt <= '0;
            end else if (w_xfer) begin
                lane_cnt <= lane_cnt + 1'b1;
            end
        end
    end

    // ==============================
    // lane steering
    // ==============================
    always_ff @(posedge m_axi_aclk) begin
        if (w_xfer) begin
            data_q.lane[lane_cnt] <= s_axi_wdata;
            if (lane_cnt == '0) begin
                // fresh word, upper strobe lanes start cleared
                strb_q.word <= m_kw'(s_axi_wstrb);
            end else begin
                strb_q.lane[lane_cnt] <= s_axi_wstrb;
            end
            last_q <= s_axi_wlast;
        end
    end

    // entry layout {last, strb, data}
    assign fifo_wdata = {last_q, strb_q.word, data_q.word};

endmodule

`default_nettype wire

// ==== hw/axi_out_slice.sv ====
// Output register between a FIFO and an AXI valid/ready channel
// holds one word until the downstream side accepts it
`timescale 1ns/1ps
`default_nettype none

module axi_out_slice #(
    parameter int width = 8
) (
    input  logic             m_axi_aclk,
    input  logic             s_axi_arst,
    input  logic             fifo_nempty,
    input  logic             fifo_rvld,
    input  logic [width-1:0] fifo_rdata,
    output logic             fifo_ren,
    output logic             out_valid,
    output logic [width-1:0] out_data,
    input  logic             out_ready
);

    // a word already popped but not yet loaded occupies the register
    assign fifo_ren = fifo_nempty & ~fifo_rvld & (~out_valid | out_ready);

    always_ff @(posedge m_axi_aclk or posedge s_axi_arst) begin
        if (s_axi_arst) begin
            out_valid <= 1'b0;
        end else if (fifo_rvld) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload only changes on a new word
    always_ff @(posedge m_axi_aclk) begin
        if (fifo_rvld) begin
            out_data <= fifo_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axi_upsize_top.sv ====
// AXI write-channel upsizer, 32-bit slave port to 128-bit master port
// AW and W are rewritten and buffered toward the master, B is buffered back
`timescale 1ns/1ps
`default_nettype none

module axi_upsize_top #(
    parameter int aw_depth = 8,
    parameter int w_depth  = 16,
    parameter int b_depth  = 8
) (
    input  logic                               m_axi_aclk,
    input  logic                               s_axi_arst,
    // slave aw
    input  logic [axi_upsize_pkg::addr_w-1:0]  s_axi_awaddr,
    input  logic [axi_upsize_pkg::id_w-1:0]    s_axi_awid,
    input  logic [axi_upsize_pkg::len_w-1:0]   s_axi_awlen,
    input  logic [axi_upsize_pkg::size_w-1:0]  s_axi_awsize,
    input  logic                               s_axi_awvalid,
    output logic                               s_axi_awready,
    // slave w
    input  logic [axi_upsize_pkg::s_dw-1:0]    s_axi_wdata,
    input  logic [axi_upsize_pkg::s_kw-1:0]    s_axi_wstrb,
    input  logic                               s_axi_wlast,
    input  logic                               s_axi_wvalid,
    output logic                               s_axi_wready,
    // slave b
    output logic [axi_upsize_pkg::id_w-1:0]    s_axi_bid,
    output logic [axi_upsize_pkg::resp_w-1:0]  s_axi_bresp,
    output logic                               s_axi_bvalid,
    input  logic                               s_axi_bready,
    // master aw
    output logic [axi_upsize_pkg::addr_w-1:0]  m_axi_awaddr,
    output logic [axi_upsize_pkg::id_w-1:0]    m_axi_awid,
    output logic [axi_upsize_pkg::len_w-1:0]   m_axi_awlen,
    output logic [axi_upsize_pkg::size_w-1:0]  m_axi_awsize,
    output logic                               m_axi_awvalid,
    input  logic                               m_axi_awready,
    // master w
    output logic [axi_upsize_pkg::m_dw-1:0]    m_axi_wdata,
    output logic [axi_upsize_pkg::m_kw-1:0]    m_axi_wstrb,
    output logic                               m_axi_wlast,
    output logic                               m_axi_wvalid,
    input  logic                               m_axi_wready,
    // master b
    input  logic [axi_upsize_pkg::id_w-1:0]    m_axi_bid,
    input  logic [axi_upsize_pkg::resp_w-1:0]  m_axi_bresp,
    input  logic                               m_axi_bvalid,
    output logic                               m_axi_bready
);

    localparam int aw_w = axi_upsize_pkg::aw_fifo_w;
    localparam int w_w  = axi_upsize_pkg::w_fifo_w;
    localparam int b_w  = axi_upsize_pkg::b_fifo_w;

    logic            aw_wen, aw_ren, aw_rvld, aw_nempty, aw_nafull;
    logic [aw_w-1:0] aw_wdata, aw_rdata, aw_out_data;
    logic            w_wen, w_ren, w_rvld, w_nempty, w_nafull;
    logic [w_w-1:0]  w_wdata, w_rdata, w_out_data;
    logic            b_wen, b_ren, b_rvld, b_nempty, b_nafull;
    logic [b_w-1:0]  b_wdata, b_rdata, b_out_data;

    // ==============================
    // AW path
    // ==============================
    aw_translate i_aw_translate (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .s_axi_awaddr (s_axi_awaddr), .s_axi_awid (s_axi_awid),
        .s_axi_awlen (s_axi_awlen), .s_axi_awsize (s_axi_awsize),
        .s_axi_awvalid (s_axi_awvalid), .s_axi_awready (s_axi_awready),
        .fifo_nafull (aw_nafull), .fifo_wen (aw_wen), .fifo_wdata (aw_wdata)
    );

    sync_fifo #(.width(aw_w), .depth(aw_depth)) i_aw_fifo (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .wen (aw_wen), .wdata (aw_wdata), .ren (aw_ren), .rdata (aw_rdata),
        .rvld (aw_rvld), .nempty (aw_nempty), .nafull (aw_nafull)
    );

    axi_out_slice #(.width(aw_w)) i_aw_slice (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .fifo_nempty (aw_nempty), .fifo_rvld (aw_rvld), .fifo_rdata (aw_rdata),
        .fifo_ren (aw_ren), .out_valid (m_axi_awvalid), .out_data (aw_out_data),
        .out_ready (m_axi_awready)
    );

    assign {m_axi_awaddr, m_axi_awid, m_axi_awlen, m_axi_awsize} = aw_out_data;

    // ==============================
    // W path
    // ==============================
    w_packer i_w_packer (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .s_axi_wdata (s_axi_wdata), .s_axi_wstrb (s_axi_wstrb),
        .s_axi_wlast (s_axi_wlast), .s_axi_wvalid (s_axi_wvalid),
        .s_axi_wready (s_axi_wready),
        .fifo_nafull (w_nafull), .fifo_wen (w_wen), .fifo_wdata (w_wdata)
    );

    sync_fifo #(.width(w_w), .depth(w_depth)) i_w_fifo (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .wen (w_wen), .wdata (w_wdata), .ren (w_ren), .rdata (w_rdata),
        .rvld (w_rvld), .nempty (w_nempty), .nafull (w_nafull)
    );

    axi_out_slice #(.width(w_w)) i_w_slice (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .fifo_nempty (w_nempty), .fifo_rvld (w_rvld), .fifo_rdata (w_rdata),
        .fifo_ren (w_ren), .out_valid (m_axi_wvalid), .out_data (w_out_data),
        .out_ready (m_axi_wready)
    );

    assign {m_axi_wlast, m_axi_wstrb, m_axi_wdata} = w_out_data;

    // ==============================
    // B path back to the slave
    // ==============================
    assign m_axi_bready = b_nafull;
    assign b_wen        = m_axi_bvalid & m_axi_bready;
    assign b_wdata      = {m_axi_bid, m_axi_bresp};

    sync_fifo #(.width(b_w), .depth(b_depth)) i_b_fifo (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .wen (b_wen), .wdata (b_wdata), .ren (b_ren), .rdata (b_rdata),
        .rvld (b_rvld), .nempty (b_nempty), .nafull (b_nafull)
    );

    axi_out_slice #(.width(b_w)) i_b_slice (
        .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
        .fifo_nempty (b_nempty), .fifo_rvld (b_rvld), .fifo_rdata (b_rdata),
        .fifo_ren (b_ren), .out_valid (s_axi_bvalid), .out_data (b_out_data),
        .out_ready (s_axi_bready)
    );

    assign {s_axi_bid, s_axi_bresp} = b_out_data;

endmodule

`default_nettype wire

// ==== verification/axi_upsize_properties.sv ====
// Handshake properties on the upsizer output channels
// a raised valid stays high with a stable payload until ready
`timescale 1ns/1ps
`default_nettype none

module axi_upsize_properties (
    input logic                              m_axi_aclk,
    input logic                              s_axi_arst,
    input logic [axi_upsize_pkg::addr_w-1:0] m_axi_awaddr,
    input logic [axi_upsize_pkg::id_w-1:0]   m_axi_awid,
    input logic [axi_upsize_pkg::len_w-1:0]  m_axi_awlen,
    input logic [axi_upsize_pkg::size_w-1:0] m_axi_awsize,
    input logic                              m_axi_awvalid,
    input logic                              m_axi_awready,
    input logic [axi_upsize_pkg::m_dw-1:0]   m_axi_wdata,
    input logic [axi_upsize_pkg::m_kw-1:0]   m_axi_wstrb,
    input logic                              m_axi_wlast,
    input logic                              m_axi_wvalid,
    input logic                              m_axi_wready,
    input logic [axi_upsize_pkg::id_w-1:0]   s_axi_bid,
    input logic [axi_upsize_pkg::resp_w-1:0] s_axi_bresp,
    input logic                              s_axi_bvalid,
    input logic                              s_axi_bready
);

    int aw_fails = 0;
    int w_fails  = 0;
    int b_fails  = 0;

    aw_hold: assert property (@(posedge m_axi_aclk) disable iff (s_axi_arst)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid
            && $stable({m_axi_awaddr, m_axi_awid, m_axi_awlen, m_axi_awsize}))
    else begin
        $error("m_axi_awvalid or its payload changed before m_axi_awready");
        aw_fails++;
    end

    w_hold: assert property (@(posedge m_axi_aclk) disable iff (s_axi_arst)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid
            && $stable({m_axi_wlast, m_axi_wstrb, m_axi_wdata}))
    else begin
        $error("m_axi_wvalid or its payload changed before m_axi_wready");
        w_fails++;
    end

    b_hold: assert property (@(posedge m_axi_aclk) disable iff (s_axi_arst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable({s_axi_bid, s_axi_bresp}))
    else begin
        $error("s_axi_bvalid or its payload changed before s_axi_bready");
        b_fails++;
    end

endmodule

bind axi_upsize_top axi_upsize_properties i_props (
    .m_axi_aclk (m_axi_aclk), .s_axi_arst (s_axi_arst),
    .m_axi_awaddr (m_axi_awaddr), .m_axi_awid (m_axi_awid),
    .m_axi_awlen (m_axi_awlen), .m_axi_awsize (m_axi_awsize),
    .m_axi_awvalid (m_axi_awvalid), .m_axi_awready (m_axi_awready),
    .m_axi_wdata (m_axi_wdata), .m_axi_wstrb (m_axi_wstrb), .m_axi_wlast (m_axi_wlast),
    .m_axi_wvalid (m_axi_wvalid), .m_axi_wready (m_axi_wready),
    .s_axi_bid (s_axi_bid), .s_axi_bresp (s_axi_bresp),
    .s_axi_bvalid (s_axi_bvalid), .s_axi_bready (s_axi_bready)
);

`default_nettype wire

// ==== verification/tb_axi_upsize.sv ====
// Testbench for the AXI write-channel upsizer
// random bursts on the 32-bit port, reference model of the 128-bit port
`timescale 1ns/1ps
`default_nettype none

module tb_axi_upsize;

    localparam int n_bursts  = 40;
    localparam int cyc_limit = n_bursts * axi_upsize_pkg::max_beats * 8 + 200;
    localparam int aw_w      = axi_upsize_pkg::aw_fifo_w;
    localparam int b_w       = axi_upsize_pkg::b_fifo_w;
    localparam int len_w     = axi_upsize_pkg::len_w;
    localparam int resp_w    = axi_upsize_pkg::resp_w;
    localparam int t_reset   = 0;
    localparam int t_aw      = 1;
    localparam int t_full    = 2;
    localparam int t_part    = 3;
    localparam int t_b       = 4;
    localparam int t_bp      = 5;

    logic                                m_axi_aclk    = 1'b0;
    logic                                s_axi_arst    = 1'b1;
    logic [axi_upsize_pkg::addr_w-1:0]   s_axi_awaddr  = '0;
    logic [axi_upsize_pkg::id_w-1:0]     s_axi_awid    = '0;
    logic [len_w-1:0]                    s_axi_awlen   = '0;
    logic [axi_upsize_pkg::size_w-1:0]   s_axi_awsize  = 3'd2;
    logic                                s_axi_awvalid = 1'b0;
    logic [axi_upsize_pkg::s_dw-1:0]     s_axi_wdata   = '0;
    logic [axi_upsize_pkg::s_kw-1:0]     s_axi_wstrb   = '0;
    logic                                s_axi_wlast   = 1'b0;
    logic                                s_axi_wvalid  = 1'b0;
    logic                                s_axi_bready  = 1'b0;
    logic                                m_axi_awready = 1'b0;
    logic                                m_axi_wready  = 1'b0;
    logic [axi_upsize_pkg::id_w-1:0]     m_axi_bid     = '0;
    logic [resp_w-1:0]                   m_axi_bresp   = '0;
    logic                                m_axi_bvalid  = 1'b0;
    logic                                s_axi_awready;
    logic                                s_axi_wready;
    logic [axi_upsize_pkg::id_w-1:0]     s_axi_bid;
    logic [resp_w-1:0]                   s_axi_bresp;
    logic                                s_axi_bvalid;
    logic [axi_upsize_pkg::addr_w-1:0]   m_axi_awaddr;
    logic [axi_upsize_pkg::id_w-1:0]     m_axi_awid;
    logic [len_w-1:0]                    m_axi_awlen;
    logic [axi_upsize_pkg::size_w-1:0]   m_axi_awsize;
    logic                                m_axi_awvalid;
    logic [axi_upsize_pkg::m_dw-1:0]     m_axi_wdata;
    logic [axi_upsize_pkg::m_kw-1:0]     m_axi_wstrb;
    logic                                m_axi_wlast;
    logic                                m_axi_wvalid;
    logic                                m_axi_bready;

    // ==============================
    // model state
    // ==============================
    logic [31:0]                         rng = 32'd41;
    logic [axi_upsize_pkg::addr_w-1:0]   aw_addr [n_bursts];
    logic [axi_upsize_pkg::id_w-1:0]     aw_id [n_bursts];
    logic [len_w-1:0]                    aw_len [n_bursts];
    logic [resp_w-1:0]                   bresp_tbl [n_bursts];
    logic [axi_upsize_pkg::s_dw-1:0]     wd_q [$];
    logic [axi_upsize_pkg::s_kw-1:0]     ws_q [$];
    logic                                wl_q [$];
    logic [aw_w-1:0]                     exp_aw_q [$];
    axi_upsize_pkg::wide_word_t          exp_wd_q [$];
    axi_upsize_pkg::wide_strb_t          exp_ws_q [$];
    logic                                exp_wl_q [$];
    int                                  exp_lanes_q [$];
    int                                  exp_wt_q [$];
    logic [b_w-1:0]                      exp_b_q [$];
    int                                  test_err [6] = '{default: 0};
    string                               test_name [6] = '{"reset", "aw_translation",
        "full_word_packing", "partial_final_word", "b_return", "back_pressure"};
    int                                  pass_cnt = 0;
    int                                  fail_cnt = 0;

    axi_upsize_top #(.aw_depth(8), .w_depth(16), .b_depth(8)) i_dut (.*);

    always #50 m_axi_aclk = ~m_axi_aclk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic report_failure(input int t, input string what);
        fail_cnt++;
        test_err[t]++;
        $display("Failure in %s: %s", test_name[t], what);
    endtask

    task automatic check_aw(input int t, input logic [aw_w-1:0] exp, input logic [aw_w-1:0] act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_err[t]++;
            $display("Error %s: expected aw %h, actual %h", test_name[t], exp, act);
        end
    endtask

    // data lanes past the burst end carry no meaning and are skipped
    task automatic check_w(input int t, input int lanes,
                           input axi_upsize_pkg::wide_word_t exp_d,
                           input axi_upsize_pkg::wide_strb_t exp_s, input logic exp_l,
                           input axi_upsize_pkg::wide_word_t act_d,
                           input axi_upsize_pkg::wide_strb_t act_s, input logic act_l);
        logic ok;
        ok = (act_s.word === exp_s.word) && (act_l === exp_l);
        for (int i = 0; i < lanes; i++) begin
            if (act_d.lane[i] !== exp_d.lane[i])
                ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_err[t]++;
            $display("Error %s: expected last %b strb %h data %h, actual last %b strb %h data %h",
                     test_name[t], exp_l, exp_s.word, exp_d.word, act_l, act_s.word, act_d.word);
        end
    endtask

    task automatic check_b(input int t,
                           input logic [axi_upsize_pkg::id_w-1:0] exp_id,
                           input logic [resp_w-1:0]               exp_resp,
                           input logic [axi_upsize_pkg::id_w-1:0] act_id,
                           input logic [resp_w-1:0]               act_resp);
        if (act_id === exp_id && act_resp === exp_resp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_err[t]++;
            $display("Error %s: expected id %h resp %h, actual id %h resp %h",
                     test_name[t], exp_id, exp_resp, act_id, act_resp);
        end
    endtask

    // narrow bursts and the wide words they should turn into
    task automatic gen_bursts();
        axi_upsize_pkg::wide_word_t wd;
        axi_upsize_pkg::wide_strb_t ws;
        int beats;
        int lane;
        for (int k = 0; k < n_bursts; k++) begin
            rng = xorshift(rng);
            beats = int'(rng[3:0]) + 1;
            aw_id[k] = rng[7:4];
            bresp_tbl[k] = rng[9:8];
            rng = xorshift(rng);
            aw_addr[k] = {rng[31:4], 4'h0};
            aw_len[k] = len_w'(beats - 1);
            exp_aw_q.push_back({aw_addr[k], aw_id[k], len_w'((beats + 3) / 4 - 1), 3'd4});
            exp_b_q.push_back({aw_id[k], bresp_tbl[k]});
            wd = '0;
            ws = '0;
            for (int b = 0; b < beats; b++) begin
                lane = b % axi_upsize_pkg::ratio;
                if (lane == 0)
                    ws = '0;
                rng = xorshift(rng);
                wd.lane[lane] = rng;
                rng = xorshift(rng);
                ws.lane[lane] = rng[3:0];
                wd_q.push_back(wd.lane[lane]);
                ws_q.push_back(rng[3:0]);
                wl_q.push_back(b == beats - 1);
                if (lane == axi_upsize_pkg::ratio - 1 || b == beats - 1) begin
                    exp_wd_q.push_back(wd);
                    exp_ws_q.push_back(ws);
                    exp_wl_q.push_back(b == beats - 1);
                    exp_lanes_q.push_back(lane + 1);
                    exp_wt_q.push_back((beats % 4 == 0) ? t_full : t_part);
                end
            end
        end
    endtask

    // ==============================
    // stimulus, slave model and checks
    // ==============================
    initial begin : main
        int cycle;
        int aw_sent;
        int w_idx;
        int aw_seen;
        int w_seen;
        int wl_seen;
        int b_issued;
        int b_seen;
        int n_words;
        int prop_fails;
        logic heavy;
        logic [31:0] st;
        logic [b_w-1:0] eb;
        cycle = 0;
        aw_sent = 0;
        w_idx = 0;
        aw_seen = 0;
        w_seen = 0;
        wl_seen = 0;
        b_issued = 0;
        b_seen = 0;
        gen_bursts();
        n_words = exp_wd_q.size();

        repeat (10) begin
            @(posedge m_axi_aclk);
            cycle++;
            if (cycle > 1 && (m_axi_awvalid !== 1'b0 || m_axi_wvalid !== 1'b0
                              || s_axi_bvalid !== 1'b0))
                report_failure(t_reset, "a valid output is high while reset is held");
        end
        s_axi_arst <= 1'b0;
        @(posedge m_axi_aclk);
        cycle++;
        if (m_axi_awvalid !== 1'b0 || m_axi_wvalid !== 1'b0 || s_axi_bvalid !== 1'b0)
            report_failure(t_reset, "a valid output is high right after reset");
        $display("test %s finished with %0d errors", test_name[t_reset], test_err[t_reset]);

        while (b_seen < n_bursts && cycle < cyc_limit) begin
            @(posedge m_axi_aclk);
            cycle++;
            if (m_axi_awvalid && m_axi_awready) begin
                if (exp_aw_q.size() == 0)
                    report_failure(t_aw, "master AW transfer with no burst pending");
                else
                    check_aw(t_aw, exp_aw_q.pop_front(),
                             {m_axi_awaddr, m_axi_awid, m_axi_awlen, m_axi_awsize});
                aw_seen++;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                if (exp_wd_q.size() == 0)
                    report_failure(t_bp, "master W transfer with no word pending");
                else
                    check_w(exp_wt_q.pop_front(), exp_lanes_q.pop_front(),
                            exp_wd_q.pop_front(), exp_ws_q.pop_front(), exp_wl_q.pop_front(),
                            m_axi_wdata, m_axi_wstrb, m_axi_wlast);
                w_seen++;
                if (m_axi_wlast)
                    wl_seen++;
            end
            if (s_axi_bvalid && s_axi_bready) begin
                if (exp_b_q.size() == 0) begin
                    report_failure(t_b, "write response with no burst pending");
                end else begin
                    eb = exp_b_q.pop_front();
                    check_b(t_b, eb[b_w-1:resp_w], eb[resp_w-1:0], s_axi_bid, s_axi_bresp);
                end
                b_seen++;
            end
            if (m_axi_bvalid && m_axi_bready)
                b_issued++;
            if (s_axi_awvalid && s_axi_awready)
                aw_sent++;
            if (s_axi_wvalid && s_axi_wready)
                w_idx++;

            // per-cycle stalls, plus a long master stall window to fill the FIFOs
            rng = xorshift(rng);
            st = rng;
            heavy = (cycle % 200) < 40;
            m_axi_awready <= (st[1:0] != 2'b00) && !heavy;
            m_axi_wready  <= (st[3:2] != 2'b00) && !heavy;
            s_axi_bready  <= (st[5:4] != 2'b00) && !heavy;
            if (!(s_axi_awvalid && !s_axi_awready)) begin
                if (aw_sent < n_bursts && st[7:6] != 2'b00) begin
                    s_axi_awvalid <= 1'b1;
                    s_axi_awaddr  <= aw_addr[aw_sent];
                    s_axi_awid    <= aw_id[aw_sent];
                    s_axi_awlen   <= aw_len[aw_sent];
                end else begin
                    s_axi_awvalid <= 1'b0;
                end
            end
            if (!(s_axi_wvalid && !s_axi_wready)) begin
                if (w_idx < wd_q.size() && st[9:8] != 2'b00) begin
                    s_axi_wvalid <= 1'b1;
                    s_axi_wdata  <= wd_q[w_idx];
                    s_axi_wstrb  <= ws_q[w_idx];
                    s_axi_wlast  <= wl_q[w_idx];
                end else begin
                    s_axi_wvalid <= 1'b0;
                end
            end
            // slave answers a burst once its address and last word have both arrived
            if (!(m_axi_bvalid && !m_axi_bready)) begin
                if (b_issued < aw_seen && b_issued < wl_seen && st[11:10] != 2'b00) begin
                    m_axi_bvalid <= 1'b1;
                    m_axi_bid    <= aw_id[b_issued];
                    m_axi_bresp  <= bresp_tbl[b_issued];
                end else begin
                    m_axi_bvalid <= 1'b0;
                end
            end
        end

        if (b_seen < n_bursts)
            report_failure(t_bp, $sformatf("the run timed out after %0d cycles", cycle));
        if (aw_seen != n_bursts || w_seen != n_words || b_seen != n_bursts)
            report_failure(t_bp, $sformatf("counts differ: aw %0d/%0d, w %0d/%0d, b %0d/%0d",
                           aw_seen, n_bursts, w_seen, n_words, b_seen, n_bursts));
        else
            pass_cnt++;
        prop_fails = i_dut.i_props.aw_fails + i_dut.i_props.w_fails + i_dut.i_props.b_fails;
        if (prop_fails != 0)
            report_failure(t_bp, $sformatf("%0d handshake assertion failures", prop_fails));
        for (int t = t_aw; t <= t_bp; t++)
            $display("test %s finished with %0d errors", test_name[t], test_err[t]);
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/axi_upsize_pkg.sv
hw/sync_fifo.sv
hw/aw_translate.sv
hw/w_packer.sv
hw/axi_out_slice.sv
hw/axi_upsize_top.sv
verification/axi_upsize_properties.sv
verification/tb_axi_upsize.sv

// ==== Makefile ====
# Verilator build and run of the AXI upsizer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_upsize
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
